//--- Makefile
TOP = tb_soc_irq

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module soc_irq_top
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- all.f
design/soc_irq_pkg.sv
design/plic_reg_pkg.sv
design/plic_gateway.sv
design/plic_pending.sv
design/plic_target.sv
design/soc_irq_top.sv
verif/tb_soc_irq.sv

//--- design/plic_gateway.sv
// level sources only, one request in flight per source; source 0 never requests
`timescale 1ns/100ps

module plic_gateway
    import soc_irq_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [NUM_SRC-1:0] src_i,         // raw levels, bit 0 reserved
    input  logic               complete_i,    // complete strobe from target
    input  src_id_t            complete_id_i, // id being completed
    output logic [NUM_SRC-1:0] req_set_o      // single pulse per new request
);

    logic [NUM_SRC-1:0] src_q;  // levels sampled on the clock
    logic [NUM_SRC-1:0] open_q; // 1 = gateway listens to its level
    logic [NUM_SRC-1:0] reopen; // decoded complete
    logic [NUM_SRC-1:0] req_d;

    ////////////////////////////////////////////////////////////////////////////
    // complete decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            reopen[i] = complete_i && (complete_id_i == src_id_t'(i));
        end
    end

    // open and high -> request now, close until complete
    assign req_d = src_q & open_q & SRC_VALID_MASK;

    ////////////////////////////////////////////////////////////////////////////
    // gateway state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            src_q     <= '0;
            open_q    <= '1; // all gateways open
            req_set_o <= '0;
        end else begin
            src_q     <= src_i;                   // request goes out one edge later
            req_set_o <= req_d;                   // pulse, pending store holds it
            open_q    <= (open_q & ~req_d) | reopen;
        end
    end

    // one pulse per request, a closed gateway waits for its complete
    // no matter how long the level stays high
    for (genvar i = 1; i < NUM_SRC; i++) begin : g_chk
        a_no_req_closed : assert property (
            @(posedge clk_i) disable iff (rst_i)
            (req_set_o[i] && !$past(reopen[i])) |=> !req_set_o[i]
        ) else $error("gateway %0d requested while closed", i);
    end

endmodule : plic_gateway

//--- design/plic_pending.sv
// pending store for one target; a set wins over a claim on the same bit
`timescale 1ns/100ps

module plic_pending
    import soc_irq_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [NUM_SRC-1:0] req_set_i,  // request pulses from gateway
    input  logic               claim_i,    // claim strobe from target
    input  src_id_t            claim_id_i, // winner at claim time, 0 = none
    output logic [NUM_SRC-1:0] pending_o
);

    logic [NUM_SRC-1:0] pending_q;
    logic [NUM_SRC-1:0] clr;

    // one-hot clear of the claimed id
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            clr[i] = claim_i && (claim_id_i == src_id_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pending register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr) | req_set_i;
        end
    end

    assign pending_o = pending_q; // level to the arbiter

    // reserved source never shows up
    a_src0_clear : assert property (@(posedge clk_i) disable iff (rst_i) !pending_q[0])
        else $error("pending bit 0 set");

    // target only claims what it saw pending
    a_claim_pending : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (claim_i && claim_id_i != '0) |-> pending_q[claim_id_i]
    ) else $error("claim of non-pending id %0d", claim_id_i);

endmodule : plic_pending

//--- design/plic_reg_pkg.sv
// word accesses only; offsets follow the standard plic layout for a single context
package plic_reg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register port
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned REG_ADDR_WIDTH = 26; // same as the plic slave window
    localparam int unsigned REG_DATA_WIDTH = 32;

    // priority and threshold share one encoding, 0 = never interrupts
    typedef logic [2:0] prio_t;

    ////////////////////////////////////////////////////////////////////////////
    // register map, byte offsets inside the plic window
    ////////////////////////////////////////////////////////////////////////////

    // one priority word per source, source n at PRIO_BASE + 4*n
    localparam logic [REG_ADDR_WIDTH-1:0] PRIO_BASE      = 26'h000_0000;

    // pending bits, read only
    localparam logic [REG_ADDR_WIDTH-1:0] PENDING_ADDR   = 26'h000_1000;

    // enable bits of context 0
    localparam logic [REG_ADDR_WIDTH-1:0] ENABLE_ADDR    = 26'h000_2000;

    // priority threshold of context 0
    localparam logic [REG_ADDR_WIDTH-1:0] THRESHOLD_ADDR = 26'h020_0000;

    // read = claim, write = complete
    localparam logic [REG_ADDR_WIDTH-1:0] CLAIM_ADDR     = 26'h020_0004;

    // everything else in the window reads as zero

endpackage : plic_reg_pkg

//--- design/plic_target.sv
// single context; reads and writes are one-cycle strobes, no wait states, word aligned
`timescale 1ns/100ps

module plic_target
    import soc_irq_pkg::*;
    import plic_reg_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      reg_we_i,    // write strobe
    input  logic                      reg_re_i,    // read strobe
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [REG_DATA_WIDTH-1:0] reg_wdata_i,
    output logic [REG_DATA_WIDTH-1:0] reg_rdata_o, // valid after the read edge
    input  logic [NUM_SRC-1:0]        pending_i,   // from pending store
    output logic                      claim_o,     // claim strobe
    output src_id_t                   claim_id_o,
    output logic                      complete_o,  // complete strobe to gateway
    output src_id_t                   complete_id_o,
    output logic                      ext_irq_o    // to the core line
);

    localparam int unsigned ID_W = $bits(src_id_t);

    prio_t              prio_q [NUM_SRC]; // entry 0 hardwired to 0
    logic [NUM_SRC-1:0] enable_q;
    prio_t              threshold_q;
    logic               ext_irq_q;

    logic [REG_ADDR_WIDTH-1:0] prio_off;
    logic                      prio_hit;
    src_id_t                   prio_idx;
    logic                      claim_hit;

    src_id_t                   win_id;
    prio_t                     win_prio;
    logic [REG_DATA_WIDTH-1:0] rdata_d;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    assign prio_off = reg_addr_i - PRIO_BASE;
    assign prio_idx = prio_off[ID_W+1:2]; // word index = source id
    assign prio_hit = (prio_off[1:0] == 2'b00) &&
                      (prio_off[REG_ADDR_WIDTH-1:2] < NUM_SRC);
    assign claim_hit = (reg_addr_i == CLAIM_ADDR);

    ////////////////////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////////////////////

    // strictly greater: threshold is the floor, lower id keeps a tie
    always_comb begin
        win_id   = '0;
        win_prio = threshold_q;
        for (int i = 1; i < NUM_SRC; i++) begin
            if (pending_i[i] && enable_q[i] && (prio_q[i] > win_prio)) begin
                win_id   = src_id_t'(i);
                win_prio = prio_q[i];
            end
        end
    end

    // claim and complete go out on the access cycle itself
    assign claim_o       = reg_re_i && claim_hit;
    assign claim_id_o    = win_id;                      // 0 when nothing qualifies
    assign complete_o    = reg_we_i && claim_hit;
    assign complete_id_o = src_id_t'(reg_wdata_i[ID_W-1:0]);

    ////////////////////////////////////////////////////////////////////////////
    // config registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_q      <= '{default: '0};
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (reg_we_i) begin
            if (prio_hit && prio_idx != '0) begin // source 0 read only
                prio_q[prio_idx] <= prio_t'(reg_wdata_i[$bits(prio_t)-1:0]);
            end
            if (reg_addr_i == ENABLE_ADDR) begin
                enable_q <= reg_wdata_i[NUM_SRC-1:0] & SRC_VALID_MASK;
            end
            if (reg_addr_i == THRESHOLD_ADDR) begin
                threshold_q <= prio_t'(reg_wdata_i[$bits(prio_t)-1:0]);
            end
            // pending and unmapped writes fall through
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_d = '0; // unmapped reads as zero
        if (prio_hit) begin
            rdata_d = REG_DATA_WIDTH'(prio_q[prio_idx]);
        end else if (reg_addr_i == PENDING_ADDR) begin
            rdata_d = REG_DATA_WIDTH'(pending_i);
        end else if (reg_addr_i == ENABLE_ADDR) begin
            rdata_d = REG_DATA_WIDTH'(enable_q);
        end else if (reg_addr_i == THRESHOLD_ADDR) begin
            rdata_d = REG_DATA_WIDTH'(threshold_q);
        end else if (claim_hit) begin
            rdata_d = REG_DATA_WIDTH'(win_id); // same id the store clears
        end
    end

    // holds until the next read
    always_ff @(posedge clk_i) begin
        if (reg_re_i) begin
            reg_rdata_o <= rdata_d;
        end
    end

    // registered request, one edge behind pending
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ext_irq_q <= 1'b0;
        end else begin
            ext_irq_q <= (win_id != '0);
        end
    end

    assign ext_irq_o = ext_irq_q;

    // nothing can beat a maxed-out threshold
    a_thr_max_quiet : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (threshold_q == '1) |=> !ext_irq_o
    ) else $error("ext_irq raised with threshold at max");

endmodule : plic_target

//--- design/soc_irq_pkg.sv
// one core target and five plic sources; widening the source count also needs a wider src_id_t
package soc_irq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // source map
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned PERIPH_IRQ_NUM = 4;                  // lines out of the peripheral bus
    localparam int unsigned NUM_SRC        = PERIPH_IRQ_NUM + 1; // plus reserved source 0

    // source numbers as seen in the plic registers
    localparam int unsigned SRC_GPIO   = 1; // gpio_in
    localparam int unsigned SRC_TIMER0 = 2;
    localparam int unsigned SRC_TIMER1 = 3;
    localparam int unsigned SRC_UART   = 4;

    // sources that may ever request, bit 0 stays out
    localparam logic [NUM_SRC-1:0] SRC_VALID_MASK = {{(NUM_SRC-1){1'b1}}, 1'b0};

    // wide enough for ids 0..NUM_SRC-1
    typedef logic [2:0] src_id_t;

    ////////////////////////////////////////////////////////////////////////////
    // core interrupt line
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned IRQ_LINE_WIDTH = 32; // irq_i of the core socket

    // machine external interrupt position, per the risc-v mip layout
    localparam int unsigned EXT_IRQ_BIT = 11;

    // all other bits of the line are tied to zero at the top

endpackage : soc_irq_pkg

//--- design/soc_irq_top.sv
// single clock domain; peripheral levels must already be synchronous to clk_i
`timescale 1ns/100ps

module soc_irq_top
    import soc_irq_pkg::*;
    import plic_reg_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [PERIPH_IRQ_NUM-1:0] periph_irq_i, // gpio, tmr0, tmr1, uart
    input  logic                      reg_we_i,
    input  logic                      reg_re_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [REG_DATA_WIDTH-1:0] reg_wdata_i,
    output logic [REG_DATA_WIDTH-1:0] reg_rdata_o,
    output logic [IRQ_LINE_WIDTH-1:0] irq_line_o    // core irq_i
);

    logic [NUM_SRC-1:0] src_line; // plic view, bit 0 reserved
    logic [NUM_SRC-1:0] req_set;  // gateway -> pending
    logic [NUM_SRC-1:0] pending;  // pending -> target
    logic               claim;
    src_id_t            claim_id;
    logic               complete;
    src_id_t            complete_id;
    logic               ext_irq;

    ////////////////////////////////////////////////////////////////////////////
    // source mapping
    ////////////////////////////////////////////////////////////////////////////

    assign src_line[0]          = 1'b0; // reserved
    assign src_line[SRC_GPIO]   = periph_irq_i[SRC_GPIO-1];
    assign src_line[SRC_TIMER0] = periph_irq_i[SRC_TIMER0-1];
    assign src_line[SRC_TIMER1] = periph_irq_i[SRC_TIMER1-1];
    assign src_line[SRC_UART]   = periph_irq_i[SRC_UART-1];

    plic_gateway gateway_u (
        .clk_i, .rst_i,
        .src_i         ( src_line    ),
        .complete_i    ( complete    ),
        .complete_id_i ( complete_id ),
        .req_set_o     ( req_set     )
    );

    plic_pending pending_u (
        .clk_i, .rst_i,
        .req_set_i  ( req_set  ),
        .claim_i    ( claim    ),
        .claim_id_i ( claim_id ),
        .pending_o  ( pending  )
    );

    plic_target target_u (
        .clk_i, .rst_i,
        .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
        .pending_i     ( pending     ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id ),
        .ext_irq_o     ( ext_irq     )
    );

    // only the external interrupt bit is wired
    always_comb begin
        irq_line_o              = '0;
        irq_line_o[EXT_IRQ_BIT] = ext_irq;
    end

endmodule : soc_irq_top

//--- verif/tb_soc_irq.sv
// directed tests for one plic context; inputs change on the falling edge, budget set by watchdog
`timescale 1ns/100ps

module tb_soc_irq
    import soc_irq_pkg::*;
    import plic_reg_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    // cycle budget per test, summed for the watchdog
    localparam int LEN_RESET     = 30;
    localparam int LEN_READBACK  = 80;
    localparam int LEN_SINGLE    = 60;
    localparam int LEN_ARB       = 160;
    localparam int LEN_THRESHOLD = 80;
    localparam int LEN_GATEWAY   = 90;
    localparam int MARGIN = 200;
    localparam int WATCHDOG_NS = (LEN_RESET + LEN_READBACK + LEN_SINGLE + LEN_ARB +
                                  LEN_THRESHOLD + LEN_GATEWAY + MARGIN) * CLK_PERIOD;

    localparam src_id_t ID_GPIO = 3'd1;
    localparam src_id_t ID_TMR0 = 3'd2;
    localparam src_id_t ID_TMR1 = 3'd3;
    localparam src_id_t ID_UART = 3'd4;
    localparam logic [IRQ_LINE_WIDTH-1:0] EXT_MASK = 32'h0000_0800; // bit 11 only

    logic                      clk, rst;
    logic [PERIPH_IRQ_NUM-1:0] periph_irq;
    logic                      we, re;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [REG_DATA_WIDTH-1:0] wdata, rdata;
    logic [IRQ_LINE_WIDTH-1:0] irq_line;

    logic [31:0]        lfsr_state = 32'hf9d585e4;
    prio_t              exp_prio [NUM_SRC]; // model of the priority registers
    logic [NUM_SRC-1:0] exp_pend;
    int                 err_count = 0;
    int                 tests_run = 0;
    int                 err_mark = 0;
    logic [31:0]        rdata_q, rnd; // scratch for the tests

    soc_irq_top UUT (
        .clk_i(clk), .rst_i(rst), .periph_irq_i(periph_irq),
        .reg_we_i(we), .reg_re_i(re), .reg_addr_i(addr), .reg_wdata_i(wdata),
        .reg_rdata_o(rdata), .irq_line_o(irq_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_line(input logic [IRQ_LINE_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0d ns: %s, irq line %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input src_id_t got, exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0d ns: %s, claim id %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [REG_DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0d ns: %s, read %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus helpers, all return on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        rst = 1'b1;
        periph_irq = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        exp_prio = '{default: '0};
        exp_pend = '0;
        err_mark = err_count; // start of a new test
    endtask

    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] a, input logic [31:0] d);
        we = 1'b1;
        addr = a;
        wdata = d;
        @(posedge clk); // takes effect here
        @(negedge clk);
        we = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] a, output logic [31:0] d);
        re = 1'b1;
        addr = a;
        @(posedge clk); // claim happens on this edge too
        @(negedge clk);
        re = 1'b0;
        d = rdata; // registered, stable mid cycle
    endtask

    task automatic set_prio(input src_id_t id, input prio_t p);
        exp_prio[id] = p;
        write_reg(PRIO_BASE + REG_ADDR_WIDTH'(4 * int'(id)), REG_DATA_WIDTH'(p));
    endtask

    // walk priority levels from the top down to just above the threshold,
    // the first id found on a level takes it
    function automatic src_id_t expect_winner(input logic [NUM_SRC-1:0] en, input prio_t thr);
        src_id_t best;
        logic    found;
        best  = '0;
        found = 1'b0;
        for (int p = (1 << $bits(prio_t)) - 1; p > int'(thr); p--) begin
            for (int i = 1; i < NUM_SRC; i++) begin
                if (!found && exp_pend[i] && en[i] && int'(exp_prio[i]) == p) begin
                    best  = src_id_t'(i);
                    found = 1'b1;
                end
            end
        end
        return best;
    endfunction

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s finished with %0d errors", name, err_count - err_mark);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_after_reset();
        apply_reset();
        check_line(irq_line, '0, "line after reset");
        read_reg(CLAIM_ADDR, rdata_q);
        check_data(rdata_q, '0, "claim after reset");
        end_test("after_reset");
    endtask

    task automatic test_readback();
        apply_reset();
        for (int s = 1; s < NUM_SRC; s++) begin
            take_bits(3, rnd);
            set_prio(src_id_t'(s), prio_t'(rnd));
        end
        for (int s = 1; s < NUM_SRC; s++) begin
            read_reg(PRIO_BASE + REG_ADDR_WIDTH'(4 * s), rdata_q);
            check_data(rdata_q, REG_DATA_WIDTH'(exp_prio[s]), "priority readback");
        end
        write_reg(ENABLE_ADDR, 32'h0000_0016);
        read_reg(ENABLE_ADDR, rdata_q);
        check_data(rdata_q, 32'h0000_0016, "enable readback");
        write_reg(THRESHOLD_ADDR, 32'h0000_0005);
        read_reg(THRESHOLD_ADDR, rdata_q);
        check_data(rdata_q, 32'h0000_0005, "threshold readback");
        read_reg(26'h000_3000, rdata_q); // hole in the map
        check_data(rdata_q, '0, "unmapped read");
        end_test("readback");
    endtask

    task automatic test_single();
        apply_reset();
        set_prio(ID_TMR0, 3'd3);
        write_reg(ENABLE_ADDR, 32'h0000_0004);
        periph_irq[1] = 1'b1; // timer 0, sampled on edge n
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_line(irq_line, '0, "line before edge n+3");
        @(negedge clk);
        check_line(irq_line, EXT_MASK, "line at edge n+3");
        periph_irq[1] = 1'b0;
        read_reg(CLAIM_ADDR, rdata_q);
        check_id(src_id_t'(rdata_q[2:0]), ID_TMR0, "single claim");
        @(negedge clk); // request follows the claim one edge later
        check_line(irq_line, '0, "line after claim");
        write_reg(CLAIM_ADDR, REG_DATA_WIDTH'(ID_TMR0));
        end_test("single_source");
    endtask

    task automatic test_arbitration();
        src_id_t            exp_id;
        logic [NUM_SRC-1:0] en_mask;
        apply_reset();
        for (int s = 1; s < NUM_SRC; s++) begin
            take_bits(3, rnd);
            set_prio(src_id_t'(s), prio_t'(rnd));
        end
        en_mask = NUM_SRC'((1 << ID_GPIO) | (1 << ID_TMR0) | (1 << ID_TMR1)); // uart left out
        write_reg(ENABLE_ADDR, REG_DATA_WIDTH'(en_mask));
        periph_irq = 4'hf;
        exp_pend = 5'b11110;
        repeat (4) @(negedge clk);
        repeat (NUM_SRC) begin
            exp_id = expect_winner(en_mask, 3'd0);
            read_reg(CLAIM_ADDR, rdata_q);
            check_id(src_id_t'(rdata_q[2:0]), exp_id, "arbitration order");
            if (exp_id != '0) begin
                exp_pend[exp_id] = 1'b0;
                periph_irq = periph_irq & ~(4'b0001 << (exp_id - 3'd1));
                write_reg(CLAIM_ADDR, REG_DATA_WIDTH'(exp_id));
            end
        end
        read_reg(PENDING_ADDR, rdata_q); // leftovers never claimed
        check_data(rdata_q, REG_DATA_WIDTH'(exp_pend), "pending after arbitration");
        end_test("arbitration");
    endtask

    task automatic test_threshold();
        apply_reset();
        set_prio(ID_UART, 3'd2);
        write_reg(ENABLE_ADDR, 32'h0000_0010);
        write_reg(THRESHOLD_ADDR, 32'h0000_0002); // equal, not above
        periph_irq[3] = 1'b1;
        repeat (4) @(negedge clk);
        check_line(irq_line, '0, "line under threshold");
        read_reg(PENDING_ADDR, rdata_q);
        check_data(rdata_q, 32'h0000_0010, "pending under threshold");
        read_reg(CLAIM_ADDR, rdata_q);
        check_id(src_id_t'(rdata_q[2:0]), '0, "claim under threshold");
        write_reg(THRESHOLD_ADDR, 32'h0000_0001);
        @(negedge clk);
        check_line(irq_line, EXT_MASK, "line after lower threshold");
        periph_irq[3] = 1'b0;
        read_reg(CLAIM_ADDR, rdata_q);
        check_id(src_id_t'(rdata_q[2:0]), ID_UART, "claim after lower threshold");
        write_reg(CLAIM_ADDR, REG_DATA_WIDTH'(ID_UART));
        end_test("threshold");
    endtask

    task automatic test_gateway();
        apply_reset();
        set_prio(ID_GPIO, 3'd5);
        write_reg(ENABLE_ADDR, 32'h0000_0002);
        periph_irq[0] = 1'b1; // held high through the whole test
        repeat (4) @(negedge clk);
        read_reg(CLAIM_ADDR, rdata_q);
        check_id(src_id_t'(rdata_q[2:0]), ID_GPIO, "gateway first claim");
        repeat (4) @(negedge clk);
        read_reg(PENDING_ADDR, rdata_q);
        check_data(rdata_q, '0, "no re-pend while closed");
        check_line(irq_line, '0, "line while closed");
        write_reg(CLAIM_ADDR, REG_DATA_WIDTH'(ID_GPIO)); // reopens
        repeat (2) @(negedge clk); // req_set then pending
        read_reg(PENDING_ADDR, rdata_q);
        check_data(rdata_q, 32'h0000_0002, "re-pend after complete");
        periph_irq[0] = 1'b0;
        end_test("gateway");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0d ns, tests did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        periph_irq = '0;
        we = 1'b0;
        re = 1'b0;
        addr = '0;
        wdata = '0;
        test_after_reset();
        test_readback();
        test_single();
        test_arbitration();
        test_threshold();
        test_gateway();
        $display("tests run %0d, errors %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_soc_irq
